//--- rv_idu.f
+incdir+common
common/rv_decode_pkg.sv
hw/rv_idu/rv_op_decode.sv
hw/rv_idu/rv_imm_gen.sv
hw/rv_idu/rv_decode_stage.sv
hw/rv_idu/rv_idu.sv
verif/tb_clk_gen.sv
verif/rv_idu_props.sv
verif/tb_rv_idu.sv

//--- verif/tb_rv_idu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_macros.svh"

module tb_rv_idu;

  logic                         clk;
  logic                         rst_n;
  logic                         inst_valid;
  logic [`RV_INST_W-1:0]        inst;
  logic                         dec_valid;
  rv_decode_pkg::decoded_inst_t dec;

  rv_decode_pkg::decoded_inst_t exp_q[$];
  rv_decode_pkg::decoded_inst_t exp_rec;
  rv_decode_pkg::decoded_inst_t last_dec;
  logic                         have_last = 1'b0;
  logic                         valid_expected = 1'b0;
  logic                         clk_started = 1'b0;
  bit                           seen_op [64];
  // Eleven legal major opcodes with SYSTEM last, then an unused one
  logic [6:0] opcode_list [12] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
                                   7'b1100011, 7'b0000011, 7'b0100011, 7'b0010011,
                                   7'b0110011, 7'b0001111, 7'b1110011, 7'b1111111};

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_idu dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .dec_valid  (dec_valid),
    .dec        (dec)
  );

  // RV32I rules keyed on {funct7, funct3, opcode}
  function automatic rv_decode_pkg::decoded_inst_t ref_decode(input logic [31:0] w);
    rv_decode_pkg::decoded_inst_t r;
    r = '0;
    casez ({w[31:25], w[14:12], w[6:0]})
      17'b???????_???_0110111: r.op = rv_decode_pkg::OP_LUI;
      17'b???????_???_0010111: r.op = rv_decode_pkg::OP_AUIPC;
      17'b???????_???_1101111: r.op = rv_decode_pkg::OP_JAL;
      17'b???????_000_1100111: r.op = rv_decode_pkg::OP_JALR;
      17'b???????_000_1100011: r.op = rv_decode_pkg::OP_BEQ;
      17'b???????_001_1100011: r.op = rv_decode_pkg::OP_BNE;
      17'b???????_100_1100011: r.op = rv_decode_pkg::OP_BLT;
      17'b???????_101_1100011: r.op = rv_decode_pkg::OP_BGE;
      17'b???????_110_1100011: r.op = rv_decode_pkg::OP_BLTU;
      17'b???????_111_1100011: r.op = rv_decode_pkg::OP_BGEU;
      17'b???????_000_0000011: r.op = rv_decode_pkg::OP_LB;
      17'b???????_001_0000011: r.op = rv_decode_pkg::OP_LH;
      17'b???????_010_0000011: r.op = rv_decode_pkg::OP_LW;
      17'b???????_100_0000011: r.op = rv_decode_pkg::OP_LBU;
      17'b???????_101_0000011: r.op = rv_decode_pkg::OP_LHU;
      17'b???????_000_0100011: r.op = rv_decode_pkg::OP_SB;
      17'b???????_001_0100011: r.op = rv_decode_pkg::OP_SH;
      17'b???????_010_0100011: r.op = rv_decode_pkg::OP_SW;
      17'b???????_000_0010011: r.op = rv_decode_pkg::OP_ADDI;
      17'b???????_010_0010011: r.op = rv_decode_pkg::OP_SLTI;
      17'b???????_011_0010011: r.op = rv_decode_pkg::OP_SLTIU;
      17'b???????_100_0010011: r.op = rv_decode_pkg::OP_XORI;
      17'b???????_110_0010011: r.op = rv_decode_pkg::OP_ORI;
      17'b???????_111_0010011: r.op = rv_decode_pkg::OP_ANDI;
      17'b0000000_001_0010011: r.op = rv_decode_pkg::OP_SLLI;
      17'b0000000_101_0010011: r.op = rv_decode_pkg::OP_SRLI;
      17'b0100000_101_0010011: r.op = rv_decode_pkg::OP_SRAI;
      17'b0000000_000_0110011: r.op = rv_decode_pkg::OP_ADD;
      17'b0100000_000_0110011: r.op = rv_decode_pkg::OP_SUB;
      17'b0000000_001_0110011: r.op = rv_decode_pkg::OP_SLL;
      17'b0000000_010_0110011: r.op = rv_decode_pkg::OP_SLT;
      17'b0000000_011_0110011: r.op = rv_decode_pkg::OP_SLTU;
      17'b0000000_100_0110011: r.op = rv_decode_pkg::OP_XOR;
      17'b0000000_101_0110011: r.op = rv_decode_pkg::OP_SRL;
      17'b0100000_101_0110011: r.op = rv_decode_pkg::OP_SRA;
      17'b0000000_110_0110011: r.op = rv_decode_pkg::OP_OR;
      17'b0000000_111_0110011: r.op = rv_decode_pkg::OP_AND;
      17'b???????_000_0001111: r.op = rv_decode_pkg::OP_FENCE;
      default: r.op = rv_decode_pkg::OP_ILLEGAL;
    endcase
    if (w == 32'h0000_0073) r.op = rv_decode_pkg::OP_ECALL;
    if (w == 32'h0010_0073) r.op = rv_decode_pkg::OP_EBREAK;
    if (r.op == rv_decode_pkg::OP_ILLEGAL) return r;
    r.opcode = w[6:0];
    case (w[6:0])
      7'b0110111, 7'b0010111: r.fmt = rv_decode_pkg::FMT_U;
      7'b1101111: r.fmt = rv_decode_pkg::FMT_J;
      7'b1100011: r.fmt = rv_decode_pkg::FMT_B;
      7'b0100011: r.fmt = rv_decode_pkg::FMT_S;
      7'b0110011: r.fmt = rv_decode_pkg::FMT_R;
      7'b1110011: r.fmt = rv_decode_pkg::FMT_NONE;
      7'b0010011: r.fmt = (w[13:12] == 2'b01) ? rv_decode_pkg::FMT_SHIFT : rv_decode_pkg::FMT_I;
      default: r.fmt = rv_decode_pkg::FMT_I;
    endcase
    case (r.fmt)
      rv_decode_pkg::FMT_I: r.imm = 32'($signed(w[31:20]));
      rv_decode_pkg::FMT_S: r.imm = 32'($signed({w[31:25], w[11:7]}));
      rv_decode_pkg::FMT_B: r.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      rv_decode_pkg::FMT_U: r.imm = {w[31:12], 12'h000};
      rv_decode_pkg::FMT_J: r.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default: r.imm = '0;
    endcase
    if (r.fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_I, rv_decode_pkg::FMT_SHIFT,
                      rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J}) r.rd = w[11:7];
    if (r.fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_I, rv_decode_pkg::FMT_SHIFT,
                      rv_decode_pkg::FMT_S, rv_decode_pkg::FMT_B}) begin
      r.rs1    = w[19:15];
      r.funct3 = w[14:12];
    end
    if (r.fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_S, rv_decode_pkg::FMT_B}) begin
      r.rs2 = w[24:20];
    end
    if (r.fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_SHIFT}) r.funct7 = w[31:25];
    if (r.fmt == rv_decode_pkg::FMT_SHIFT) r.shamt = w[24:20];
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [79:0] got,
                             input logic [79:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%0h, expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  task automatic compare_record(input rv_decode_pkg::decoded_inst_t got,
                                input rv_decode_pkg::decoded_inst_t exp);
    check_value("dec.op", got.op, exp.op);
    check_value("dec.fmt", got.fmt, exp.fmt);
    check_value("dec.opcode", got.opcode, exp.opcode);
    check_value("dec.imm", got.imm, exp.imm);
    check_value("dec.rd", got.rd, exp.rd);
    check_value("dec.rs1", got.rs1, exp.rs1);
    check_value("dec.rs2", got.rs2, exp.rs2);
    check_value("dec.shamt", got.shamt, exp.shamt);
    check_value("dec.funct3", got.funct3, exp.funct3);
    check_value("dec.funct7", got.funct7, exp.funct7);
  endtask

  task automatic drive_word(input logic [31:0] w);
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = w;
    exp_q.push_back(ref_decode(w));
  endtask

  task automatic drive_idle();
    @(negedge clk);
    inst_valid = 1'b0;
    inst       = $urandom; // Must be ignored
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) abort_run("Reset was never released");
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      abort_run($sformatf("Timeout: %0d decoded results never came out", exp_q.size()));
    end
  endtask

  always @(posedge clk) begin
    valid_expected <= rst_n && inst_valid;
    clk_started    <= 1'b1;
  end

  // The clock's first change from X is a falling edge with nothing registered yet
  always @(negedge clk) begin
    if (clk_started) begin
      check_value("dec_valid", dec_valid, valid_expected);
      if (dec_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("dec_valid asserted with no instruction outstanding");
        end else begin
          exp_rec = exp_q.pop_front();
          compare_record(dec, exp_rec);
          seen_op[dec.op] = 1'b1;
          last_dec  = dec;
          have_last = 1'b1;
        end
      end else if (have_last) begin
        check_value("dec (held)", dec, last_dec);
      end
    end
  end

  initial begin
    logic [31:0] w;
    int          missing;
    void'($urandom(32'he72f));
    inst_valid = 1'b0;
    inst       = '0;
    wait_reset();
    repeat (3) drive_idle(); // dec_valid stays low until a valid word
    // Every opcode and funct3, with funct7 zero, alternate, or random and negative
    foreach (opcode_list[i]) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int v = 0; v < 3; v++) begin
          w        = $urandom;
          w[6:0]   = opcode_list[i];
          w[14:12] = f3[2:0];
          if (v == 0) w[31:25] = 7'h00;
          else if (v == 1) w[31:25] = 7'h20;
          else w[31] = 1'b1;
          drive_word(w);
        end
      end
    end
    drive_word(32'h0000_0073); // ECALL
    drive_word(32'h0010_0073); // EBREAK
    drive_word(32'h0020_0073);
    drive_word(32'h0000_00f3); // ECALL with rd set
    for (int k = 0; k < 2000; k++) begin
      w = $urandom;
      if (k % 2 == 0) w[6:0] = opcode_list[$urandom_range(10, 0)];
      if ($urandom_range(3, 0) == 0) drive_idle();
      drive_word(w);
    end
    drive_idle();
    wait_drained();
    missing = 0;
    for (int k = 0; k <= int'(rv_decode_pkg::OP_EBREAK); k++) begin
      if (!seen_op[k]) missing++;
    end
    if (missing != 0) begin
      abort_run($sformatf("%0d operations were never decoded", missing));
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verif/rv_idu_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_idu_props (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         inst_valid,
  input logic                         dec_valid,
  input rv_decode_pkg::decoded_inst_t dec
);

  a_valid_low_after_reset: assert property (@(posedge clk) !rst_n |=> !dec_valid)
    else $error("dec_valid high on the cycle after reset");

  a_valid_follows_input: assert property (
    @(posedge clk) rst_n |=> (dec_valid == $past(inst_valid)))
    else $error("dec_valid does not follow inst_valid by one cycle");

  // Rejected words carry no fields at all
  a_illegal_is_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    (dec_valid && dec.op == rv_decode_pkg::OP_ILLEGAL) |->
    ({dec.fmt, dec.opcode, dec.imm, dec.rd, dec.rs1, dec.rs2,
      dec.shamt, dec.funct3, dec.funct7} == '0))
    else $error("OP_ILLEGAL output with nonzero fields");

endmodule

bind rv_idu rv_idu_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .inst_valid (inst_valid),
  .dec_valid  (dec_valid),
  .dec        (dec)
);

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/rv_idu/rv_idu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_idu (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         inst_valid,
  input  logic [`RV_INST_W-1:0]        inst,
  output logic                         dec_valid,
  output rv_decode_pkg::decoded_inst_t dec
);

  rv_decode_pkg::inst_op_e  op;
  rv_decode_pkg::inst_fmt_e fmt;
  logic [`RV_XLEN-1:0]      imm;

  rv_op_decode u_op_decode (
    .inst (inst),
    .op   (op),
    .fmt  (fmt)
  );

  rv_imm_gen u_imm_gen (
    .inst (inst),
    .fmt  (fmt),
    .imm  (imm)
  );

  rv_decode_stage u_decode_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .op         (op),
    .fmt        (fmt),
    .imm        (imm),
    .dec_valid  (dec_valid),
    .dec        (dec)
  );

endmodule

`default_nettype wire

//--- hw/rv_idu/rv_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        inst_valid,
  input  logic [`RV_INST_W-1:0]       inst,
  input  rv_decode_pkg::inst_op_e     op,
  input  rv_decode_pkg::inst_fmt_e    fmt,
  input  logic [`RV_XLEN-1:0]         imm,
  output logic                        dec_valid,
  output rv_decode_pkg::decoded_inst_t dec
);

  rv_decode_pkg::inst_fields_t  f;
  rv_decode_pkg::decoded_inst_t dec_next;

  assign f = inst;

  always_comb begin
    dec_next        = '0;
    dec_next.op     = op;
    dec_next.fmt    = fmt;
    dec_next.opcode = f.opcode;
    dec_next.imm    = imm;
    case (fmt)
      rv_decode_pkg::FMT_R: begin
        dec_next.rd     = f.rd;
        dec_next.rs1    = f.rs1;
        dec_next.rs2    = f.rs2;
        dec_next.funct3 = f.funct3;
        dec_next.funct7 = f.funct7;
      end
      rv_decode_pkg::FMT_I: begin
        dec_next.rd     = f.rd;
        dec_next.rs1    = f.rs1;
        dec_next.funct3 = f.funct3;
      end
      rv_decode_pkg::FMT_SHIFT: begin
        dec_next.rd     = f.rd;
        dec_next.rs1    = f.rs1;
        dec_next.funct3 = f.funct3;
        dec_next.funct7 = f.funct7;
        dec_next.shamt  = f.rs2; // Bits 24:20
      end
      rv_decode_pkg::FMT_S, rv_decode_pkg::FMT_B: begin
        dec_next.rs1    = f.rs1;
        dec_next.rs2    = f.rs2;
        dec_next.funct3 = f.funct3;
      end
      rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J: begin
        dec_next.rd = f.rd;
      end
      default: ;
    endcase
    if (op == rv_decode_pkg::OP_ILLEGAL) begin
      dec_next     = '0; // Opcode dropped too
      dec_next.op  = rv_decode_pkg::OP_ILLEGAL;
      dec_next.fmt = rv_decode_pkg::FMT_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) dec_valid <= 1'b0;
    else dec_valid <= inst_valid;
  end

  always_ff @(posedge clk) begin
    if (inst_valid) dec <= dec_next; // Held across gaps
  end

endmodule

`default_nettype wire

//--- hw/rv_idu/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_imm_gen (
  input  logic [`RV_INST_W-1:0]    inst,
  input  rv_decode_pkg::inst_fmt_e fmt,
  output logic [`RV_XLEN-1:0]      imm
);

  logic sign;

  assign sign = inst[`RV_INST_W-1];

  always_comb begin
    case (fmt)
      rv_decode_pkg::FMT_I: begin
        imm = {{(`RV_XLEN-12){sign}}, inst[31:20]};
      end
      rv_decode_pkg::FMT_S: begin
        imm = {{(`RV_XLEN-12){sign}}, inst[31:25], inst[11:7]};
      end
      rv_decode_pkg::FMT_B: begin
        // Byte offset with bit 0 always zero
        imm = {{(`RV_XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
               inst[11:8], 1'b0};
      end
      rv_decode_pkg::FMT_U: begin
        imm = {inst[31:12], 12'b0};
      end
      rv_decode_pkg::FMT_J: begin
        imm = {{(`RV_XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
               inst[30:21], 1'b0};
      end
      default: begin
        imm = '0; // R, SHIFT and NONE carry no immediate
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/rv_idu/rv_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_op_decode (
  input  logic [`RV_INST_W-1:0]  inst,
  output rv_decode_pkg::inst_op_e  op,
  output rv_decode_pkg::inst_fmt_e fmt
);

  rv_decode_pkg::inst_fields_t f;
  logic                        f7_zero;
  logic                        f7_alt;
  logic [11:0]                 sys_imm;

  assign f       = inst;
  assign f7_zero = (f.funct7 == 7'b0000000);
  assign f7_alt  = (f.funct7 == 7'b0100000); // SUB, SRA, SRAI
  assign sys_imm = {f.funct7, f.rs2};

  always_comb begin
    op  = rv_decode_pkg::OP_ILLEGAL;
    fmt = rv_decode_pkg::FMT_NONE;
    case (f.opcode)
      rv_decode_pkg::OPC_LUI: begin
        op  = rv_decode_pkg::OP_LUI;
        fmt = rv_decode_pkg::FMT_U;
      end
      rv_decode_pkg::OPC_AUIPC: begin
        op  = rv_decode_pkg::OP_AUIPC;
        fmt = rv_decode_pkg::FMT_U;
      end
      rv_decode_pkg::OPC_JAL: begin
        op  = rv_decode_pkg::OP_JAL;
        fmt = rv_decode_pkg::FMT_J;
      end
      rv_decode_pkg::OPC_JALR: begin
        fmt = rv_decode_pkg::FMT_I;
        if (f.funct3 == 3'b000) op = rv_decode_pkg::OP_JALR;
      end
      rv_decode_pkg::OPC_BRANCH: begin
        fmt = rv_decode_pkg::FMT_B;
        case (f.funct3)
          3'b000:  op = rv_decode_pkg::OP_BEQ;
          3'b001:  op = rv_decode_pkg::OP_BNE;
          3'b100:  op = rv_decode_pkg::OP_BLT;
          3'b101:  op = rv_decode_pkg::OP_BGE;
          3'b110:  op = rv_decode_pkg::OP_BLTU;
          3'b111:  op = rv_decode_pkg::OP_BGEU;
          default: op = rv_decode_pkg::OP_ILLEGAL;
        endcase
      end
      rv_decode_pkg::OPC_LOAD: begin
        fmt = rv_decode_pkg::FMT_I;
        case (f.funct3)
          3'b000:  op = rv_decode_pkg::OP_LB;
          3'b001:  op = rv_decode_pkg::OP_LH;
          3'b010:  op = rv_decode_pkg::OP_LW;
          3'b100:  op = rv_decode_pkg::OP_LBU;
          3'b101:  op = rv_decode_pkg::OP_LHU;
          default: op = rv_decode_pkg::OP_ILLEGAL;
        endcase
      end
      rv_decode_pkg::OPC_STORE: begin
        fmt = rv_decode_pkg::FMT_S;
        case (f.funct3)
          3'b000:  op = rv_decode_pkg::OP_SB;
          3'b001:  op = rv_decode_pkg::OP_SH;
          3'b010:  op = rv_decode_pkg::OP_SW;
          default: op = rv_decode_pkg::OP_ILLEGAL;
        endcase
      end
      rv_decode_pkg::OPC_OP_IMM: begin
        fmt = rv_decode_pkg::FMT_I;
        case (f.funct3)
          3'b000: op = rv_decode_pkg::OP_ADDI;
          3'b010: op = rv_decode_pkg::OP_SLTI;
          3'b011: op = rv_decode_pkg::OP_SLTIU;
          3'b100: op = rv_decode_pkg::OP_XORI;
          3'b110: op = rv_decode_pkg::OP_ORI;
          3'b111: op = rv_decode_pkg::OP_ANDI;
          3'b001: begin
            fmt = rv_decode_pkg::FMT_SHIFT;
            if (f7_zero) op = rv_decode_pkg::OP_SLLI;
          end
          default: begin // Funct3 101 is SRLI or SRAI
            fmt = rv_decode_pkg::FMT_SHIFT;
            if (f7_zero) op = rv_decode_pkg::OP_SRLI;
            else if (f7_alt) op = rv_decode_pkg::OP_SRAI;
          end
        endcase
      end
      rv_decode_pkg::OPC_OP: begin
        fmt = rv_decode_pkg::FMT_R;
        if (f7_zero) begin
          case (f.funct3)
            3'b000:  op = rv_decode_pkg::OP_ADD;
            3'b001:  op = rv_decode_pkg::OP_SLL;
            3'b010:  op = rv_decode_pkg::OP_SLT;
            3'b011:  op = rv_decode_pkg::OP_SLTU;
            3'b100:  op = rv_decode_pkg::OP_XOR;
            3'b101:  op = rv_decode_pkg::OP_SRL;
            3'b110:  op = rv_decode_pkg::OP_OR;
            default: op = rv_decode_pkg::OP_AND;
          endcase
        end else if (f7_alt && f.funct3 == 3'b000) begin
          op = rv_decode_pkg::OP_SUB;
        end else if (f7_alt && f.funct3 == 3'b101) begin
          op = rv_decode_pkg::OP_SRA;
        end
      end
      rv_decode_pkg::OPC_MISC_MEM: begin
        fmt = rv_decode_pkg::FMT_I; // fm/pred/succ ride in the immediate
        if (f.funct3 == 3'b000) op = rv_decode_pkg::OP_FENCE;
      end
      rv_decode_pkg::OPC_SYSTEM: begin
        if (f.rd == '0 && f.rs1 == '0 && f.funct3 == 3'b000) begin
          if (sys_imm == 12'd0) op = rv_decode_pkg::OP_ECALL;
          else if (sys_imm == 12'd1) op = rv_decode_pkg::OP_EBREAK;
        end
      end
      default: op = rv_decode_pkg::OP_ILLEGAL;
    endcase
    if (op == rv_decode_pkg::OP_ILLEGAL) fmt = rv_decode_pkg::FMT_NONE;
  end

endmodule

`default_nettype wire

//--- common/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

  typedef enum logic [`RV_OPCODE_W-1:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // Illegal is zero so a rejected word gives an all-zero record
  typedef enum logic [5:0] {
    OP_ILLEGAL = 6'd0,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW,
    OP_ADDI,
    OP_SLTI,
    OP_SLTIU,
    OP_XORI,
    OP_ORI,
    OP_ANDI,
    OP_SLLI,
    OP_SRLI,
    OP_SRAI,
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_FENCE,
    OP_ECALL,
    OP_EBREAK
  } inst_op_e;

  typedef enum logic [2:0] {
    FMT_NONE  = 3'd0,
    FMT_R     = 3'd1,
    FMT_I     = 3'd2,
    FMT_SHIFT = 3'd3,
    FMT_S     = 3'd4,
    FMT_B     = 3'd5,
    FMT_U     = 3'd6,
    FMT_J     = 3'd7
  } inst_fmt_e;

  // Raw word split at the R-type field positions
  typedef struct packed {
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_OPCODE_W-1:0]   opcode;
  } inst_fields_t;

  typedef struct packed {
    inst_op_e                  op;
    inst_fmt_e                 fmt;
    logic [`RV_OPCODE_W-1:0]   opcode;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] shamt;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
  } decoded_inst_t;

endpackage

`default_nettype wire

//--- common/rv_decode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Instruction word width
`define RV_INST_W 32

// Datapath and immediate width
`define RV_XLEN 32

// Register index width
`define RV_REG_ADDR_W 5

// Major opcode width
`define RV_OPCODE_W 7

`endif
